// ==== Makefile ====
TOP = tbGshareFrontEnd

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f gshareFrontEnd.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f gshareFrontEnd.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== gshareFrontEnd.f ====
hw/frontEndPkg.sv
hw/fetchControl.sv
hw/pcPipeline.sv
hw/branchTargetBuffer.sv
hw/gsharePredictor.sv
hw/branchResolver.sv
hw/gshareFrontEnd.sv
sim/tbGshareFrontEnd.sv

// ==== hw/branchResolver.sv ====
// Execute-stage branch resolution, purely combinational
// Operand values come from outside the front end
// Only conditional branches and JAL are resolved here
`timescale 1ns/100ps

module branchResolver (
    input  logic                         validE_i,
    input  logic                         isBranchE_i,
    input  logic                         isJalE_i,
    input  logic [2:0]                   funct3E_i,
    input  logic [frontEndPkg::XLEN-1:0] pcE_i,
    input  logic [frontEndPkg::XLEN-1:0] immE_i,
    input  logic [frontEndPkg::XLEN-1:0] predNextPcE_i,
    input  logic [frontEndPkg::XLEN-1:0] rs1Val_i,
    input  logic [frontEndPkg::XLEN-1:0] rs2Val_i,
    output logic                         takenE_o,
    output logic [frontEndPkg::XLEN-1:0] targetE_o,
    output logic                         mispredictE_o,
    output logic [frontEndPkg::XLEN-1:0] correctPcE_o,
    output logic                         updateBtbE_o,
    output logic                         updatePhtE_o
);

    import frontEndPkg::*;

    logic condTrue;

    always_comb begin
        case (funct3E_i)
            BEQ:     condTrue = (rs1Val_i == rs2Val_i);
            BNE:     condTrue = (rs1Val_i != rs2Val_i);
            BLT:     condTrue = ($signed(rs1Val_i) < $signed(rs2Val_i));
            BGE:     condTrue = ($signed(rs1Val_i) >= $signed(rs2Val_i));
            BLTU:    condTrue = (rs1Val_i < rs2Val_i);
            BGEU:    condTrue = (rs1Val_i >= rs2Val_i);
            default: condTrue = 1'b0;
        endcase
    end

    assign takenE_o  = isJalE_i | (isBranchE_i & condTrue);
    assign targetE_o = pcE_i + immE_i;

    // Resolved next PC, compared against what fetch actually followed
    assign correctPcE_o  = takenE_o ? targetE_o : pcE_i + XLEN'(4);
    assign mispredictE_o = validE_i && (correctPcE_o != predNextPcE_i);

    // Training only from instructions on the real path
    assign updateBtbE_o = validE_i & takenE_o;
    assign updatePhtE_o = validE_i & isBranchE_i;

    // Decode must only flag branches with one of the six conditions
    always_comb begin
        legalFunct3: assert #0 (!(validE_i && isBranchE_i) ||
                                (funct3E_i inside {BEQ, BNE, BLT, BGE, BLTU, BGEU}));
    end

endmodule

// ==== hw/branchTargetBuffer.sv ====
// Direct-mapped BTB with full tags above the index
// Lookup is combinational from the fetch PC, writes land at the clock edge
// BTB_ENTRIES must be a power of two
`timescale 1ns/100ps

module branchTargetBuffer #(
    parameter int BTB_ENTRIES = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [frontEndPkg::XLEN-1:0] pcF_i,
    input  logic                         we_i,
    input  logic [frontEndPkg::XLEN-1:0] writePc_i,
    input  logic [frontEndPkg::XLEN-1:0] writeTarget_i,
    input  logic                         writeJump_i,
    output logic                         hitF_o,
    output logic [frontEndPkg::XLEN-1:0] targetF_o,
    output logic                         jumpF_o
);

    import frontEndPkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;

    logic [BTB_ENTRIES-1:0] validArr;
    logic [TAG_W-1:0]       tagArr    [BTB_ENTRIES];
    logic [XLEN-1:0]        targetArr [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] jumpArr;

    logic [IDX_W-1:0] readIdx;
    logic [IDX_W-1:0] writeIdx;

    // Bits 1:0 are always zero for aligned fetches
    assign readIdx  = pcF_i[IDX_W+1:2];
    assign writeIdx = writePc_i[IDX_W+1:2];

    assign hitF_o    = validArr[readIdx] && (tagArr[readIdx] == pcF_i[XLEN-1:IDX_W+2]);
    assign targetF_o = targetArr[readIdx];
    assign jumpF_o   = jumpArr[readIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            validArr <= '0;
        end else if (we_i) begin
            validArr[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tagArr[writeIdx]    <= writePc_i[XLEN-1:IDX_W+2];
            targetArr[writeIdx] <= writeTarget_i;
            jumpArr[writeIdx]   <= writeJump_i;
        end
    end

    // Targets come from the execute adder and must stay word aligned
    alignedTarget: assert property (
        @(posedge clk) disable iff (reset)
        we_i |-> (writeTarget_i[1:0] == 2'b00)
    );

endmodule

// ==== hw/fetchControl.sv ====
// Stall, flush and valid tracking for fetch, decode and execute
// A misprediction always wins over an external stall
// A stall holds fetch and decode and sends a bubble into execute
`timescale 1ns/100ps

module fetchControl (
    input  logic clk,
    input  logic reset,
    input  logic stall_i,
    input  logic mispredictE_i,
    output logic stallF_o,
    output logic stallD_o,
    output logic flushD_o,
    output logic flushE_o,
    output logic validD_o,
    output logic validE_o
);

    // Redirect cancels the stall so the corrected PC is taken at once
    assign stallF_o = stall_i & ~mispredictE_i;
    assign stallD_o = stall_i & ~mispredictE_i;
    assign flushD_o = mispredictE_i;
    assign flushE_o = mispredictE_i | stall_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            validD_o <= 1'b0;
            validE_o <= 1'b0;
        end else begin
            if (flushD_o) begin
                validD_o <= 1'b0;
            end else if (!stallD_o) begin
                validD_o <= 1'b1;
            end
            // Bubble into execute on a flush or stall
            validE_o <= flushE_o ? 1'b0 : validD_o;
        end
    end

    // A redirect only comes from a valid execute stage and empties both younger stages
    redirectNotLost: assert property (
        @(posedge clk) disable iff (reset)
        mispredictE_i |-> validE_o ##1 (!validD_o && !validE_o)
    );

endmodule

// ==== hw/frontEndPkg.sv ====
// Shared constants for the fetch front end
// Only RV32 base encodings for JAL and the B-type group are decoded
// Counter encoding keeps the taken prediction in the top bit
package frontEndPkg;

    // Datapath width for PCs, instructions and operands
    localparam int XLEN = 32;

    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

    // funct3 codes of the conditional branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branchCondT;

    // 2-bit saturating counter states
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctrT;

endpackage

// ==== hw/gshareFrontEnd.sv ====
// Fetch front end with BTB and gshare prediction
// instrF_i must be returned combinationally for pcF_o
// Execute operands are supplied by the surrounding core
`timescale 1ns/100ps

module gshareFrontEnd #(
    parameter logic [frontEndPkg::XLEN-1:0] PC_START = '0,
    parameter int BTB_ENTRIES = 32,
    parameter int GHR_BITS    = 3,
    parameter int PHT_ENTRIES = 1024
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall_i,
    input  logic [frontEndPkg::XLEN-1:0] instrF_i,
    input  logic [frontEndPkg::XLEN-1:0] rs1ValE_i,
    input  logic [frontEndPkg::XLEN-1:0] rs2ValE_i,
    output logic [frontEndPkg::XLEN-1:0] pcF_o,
    output logic                         validE_o,
    output logic [frontEndPkg::XLEN-1:0] pcE_o,
    output logic                         mispredictE_o,
    output logic [frontEndPkg::XLEN-1:0] correctPcE_o
);

    import frontEndPkg::*;

    localparam int IDX_W = $clog2(PHT_ENTRIES);

    logic             stallF, stallD, flushD, flushE;
    logic             btbHitF, btbJumpF, predTakenF;
    logic [XLEN-1:0]  btbTargetF;
    logic [IDX_W-1:0] phtIndexF, phtIndexE;
    logic [XLEN-1:0]  immE, predNextPcE, targetE;
    logic [2:0]       funct3E;
    logic             isBranchE, isJalE, takenE;
    logic             updateBtbE, updatePhtE;

    fetchControl u_fetchControl (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .mispredictE_i(mispredictE_o),
        .stallF_o     (stallF),
        .stallD_o     (stallD),
        .flushD_o     (flushD),
        .flushE_o     (flushE),
        .validD_o     (),
        .validE_o     (validE_o)
    );

    pcPipeline #(
        .PC_START   (PC_START),
        .PHT_ENTRIES(PHT_ENTRIES)
    ) u_pcPipeline (
        .clk          (clk),
        .reset        (reset),
        .instrF_i     (instrF_i),
        .btbHitF_i    (btbHitF),
        .btbJumpF_i   (btbJumpF),
        .btbTargetF_i (btbTargetF),
        .predTakenF_i (predTakenF),
        .phtIndexF_i  (phtIndexF),
        .stallF_i     (stallF),
        .stallD_i     (stallD),
        .flushD_i     (flushD),
        .flushE_i     (flushE),
        .redirect_i   (mispredictE_o),
        .correctPc_i  (correctPcE_o),
        .pcF_o        (pcF_o),
        .pcE_o        (pcE_o),
        .immE_o       (immE),
        .funct3E_o    (funct3E),
        .isBranchE_o  (isBranchE),
        .isJalE_o     (isJalE),
        .predNextPcE_o(predNextPcE),
        .phtIndexE_o  (phtIndexE)
    );

    branchTargetBuffer #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_branchTargetBuffer (
        .clk          (clk),
        .reset        (reset),
        .pcF_i        (pcF_o),
        .we_i         (updateBtbE),
        .writePc_i    (pcE_o),
        .writeTarget_i(targetE),
        .writeJump_i  (isJalE),
        .hitF_o       (btbHitF),
        .targetF_o    (btbTargetF),
        .jumpF_o      (btbJumpF)
    );

    gsharePredictor #(
        .GHR_BITS   (GHR_BITS),
        .PHT_ENTRIES(PHT_ENTRIES)
    ) u_gsharePredictor (
        .clk         (clk),
        .reset       (reset),
        .pcF_i       (pcF_o),
        .update_i    (updatePhtE),
        .takenE_i    (takenE),
        .indexE_i    (phtIndexE),
        .predTakenF_o(predTakenF),
        .indexF_o    (phtIndexF)
    );

    branchResolver u_branchResolver (
        .validE_i     (validE_o),
        .isBranchE_i  (isBranchE),
        .isJalE_i     (isJalE),
        .funct3E_i    (funct3E),
        .pcE_i        (pcE_o),
        .immE_i       (immE),
        .predNextPcE_i(predNextPcE),
        .rs1Val_i     (rs1ValE_i),
        .rs2Val_i     (rs2ValE_i),
        .takenE_o     (takenE),
        .targetE_o    (targetE),
        .mispredictE_o(mispredictE_o),
        .correctPcE_o (correctPcE_o),
        .updateBtbE_o (updateBtbE),
        .updatePhtE_o (updatePhtE)
    );

endmodule

// ==== hw/gsharePredictor.sv ====
// Gshare direction predictor, 2-bit counters indexed by PC xor history
// History is updated only from resolved branches in execute
// GHR_BITS must not exceed the index width
`timescale 1ns/100ps

module gsharePredictor #(
    parameter int GHR_BITS    = 3,
    parameter int PHT_ENTRIES = 1024
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [frontEndPkg::XLEN-1:0]   pcF_i,
    input  logic                           update_i,
    input  logic                           takenE_i,
    input  logic [$clog2(PHT_ENTRIES)-1:0] indexE_i,
    output logic                           predTakenF_o,
    output logic [$clog2(PHT_ENTRIES)-1:0] indexF_o
);

    import frontEndPkg::*;

    localparam int IDX_W = $clog2(PHT_ENTRIES);

    logic [GHR_BITS-1:0] ghr;
    ctrT                 pht [PHT_ENTRIES];
    ctrT                 curCtr;
    ctrT                 nextCtr;

    assign indexF_o     = pcF_i[IDX_W+1:2] ^ {{(IDX_W-GHR_BITS){1'b0}}, ghr};
    assign predTakenF_o = pht[indexF_o][1];

    // Saturating step toward the resolved direction
    assign curCtr = pht[indexE_i];

    always_comb begin
        case (curCtr)
            STRONG_NT: nextCtr = takenE_i ? WEAK_NT : STRONG_NT;
            WEAK_NT:   nextCtr = takenE_i ? WEAK_T : STRONG_NT;
            WEAK_T:    nextCtr = takenE_i ? STRONG_T : WEAK_NT;
            default:   nextCtr = takenE_i ? STRONG_T : WEAK_T;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= WEAK_NT;
            end
        end else if (update_i) begin
            pht[indexE_i] <= nextCtr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (update_i) begin
            ghr <= {ghr[GHR_BITS-2:0], takenE_i};
        end
    end

endmodule

// ==== hw/pcPipeline.sv ====
// PC register, next-PC select and the F/D and D/E registers
// Instruction word must arrive in the same cycle as pcF_o
// Only B-type and JAL immediates are produced
`timescale 1ns/100ps

module pcPipeline #(
    parameter logic [frontEndPkg::XLEN-1:0] PC_START = '0,
    parameter int PHT_ENTRIES = 1024
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [frontEndPkg::XLEN-1:0]   instrF_i,
    input  logic                           btbHitF_i,
    input  logic                           btbJumpF_i,
    input  logic [frontEndPkg::XLEN-1:0]   btbTargetF_i,
    input  logic                           predTakenF_i,
    input  logic [$clog2(PHT_ENTRIES)-1:0] phtIndexF_i,
    input  logic                           stallF_i,
    input  logic                           stallD_i,
    input  logic                           flushD_i,
    input  logic                           flushE_i,
    input  logic                           redirect_i,
    input  logic [frontEndPkg::XLEN-1:0]   correctPc_i,
    output logic [frontEndPkg::XLEN-1:0]   pcF_o,
    output logic [frontEndPkg::XLEN-1:0]   pcE_o,
    output logic [frontEndPkg::XLEN-1:0]   immE_o,
    output logic [2:0]                     funct3E_o,
    output logic                           isBranchE_o,
    output logic                           isJalE_o,
    output logic [frontEndPkg::XLEN-1:0]   predNextPcE_o,
    output logic [$clog2(PHT_ENTRIES)-1:0] phtIndexE_o
);

    import frontEndPkg::*;

    localparam int IDX_W = $clog2(PHT_ENTRIES);

    logic             predTakenF;
    logic [XLEN-1:0]  predNextPcF;
    logic [XLEN-1:0]  nextPc;
    logic [XLEN-1:0]  instrD;
    logic [XLEN-1:0]  pcD;
    logic [XLEN-1:0]  predNextPcD;
    logic [IDX_W-1:0] phtIndexD;
    logic [6:0]       opcodeD;
    logic             isBranchD;
    logic             isJalD;
    logic [XLEN-1:0]  immD;

    // JAL entries in the BTB are always taken
    assign predTakenF  = btbHitF_i & (btbJumpF_i | predTakenF_i);
    assign predNextPcF = predTakenF ? btbTargetF_i : pcF_o + XLEN'(4);
    assign nextPc      = redirect_i ? correctPc_i : predNextPcF;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= PC_START;
        end else if (!stallF_i) begin
            pcF_o <= nextPc;
        end
    end

    // F/D register, a cleared word decodes as neither branch nor jump
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD <= '0;
        end else if (!stallD_i) begin
            instrD <= instrF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD         <= pcF_o;
            predNextPcD <= predNextPcF;
            phtIndexD   <= phtIndexF_i;
        end
    end

    // Decode
    assign opcodeD   = instrD[6:0];
    assign isBranchD = (opcodeD == OPCODE_BRANCH);
    assign isJalD    = (opcodeD == OPCODE_JAL);

    always_comb begin
        if (isJalD) begin
            immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
        end else begin
            immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
        end
    end

    // D/E register, stalls reach execute only as flushes
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            isBranchE_o <= 1'b0;
            isJalE_o    <= 1'b0;
        end else begin
            isBranchE_o <= isBranchD;
            isJalE_o    <= isJalD;
        end
    end

    always_ff @(posedge clk) begin
        pcE_o         <= pcD;
        immE_o        <= immD;
        funct3E_o     <= instrD[14:12];
        predNextPcE_o <= predNextPcD;
        phtIndexE_o   <= phtIndexD;
    end

endmodule

// ==== sim/tbGshareFrontEnd.sv ====
// Testbench for the gshare fetch front end
// Program and branch outcomes come from the scenario table below
// Operands are driven for the instruction entering execute, tracked by a small pipeline model
`timescale 1ns/100ps

module tbGshareFrontEnd;

    import frontEndPkg::*;

    localparam logic [31:0] PC_START = 32'h0000_0000;
    localparam int          GHR_BITS = 3;
    localparam int          NROWS    = 4;
    localparam int          MAXPASS  = 8;
    localparam logic [31:0] NOP      = 32'h0000_0013;

    logic        clk;
    logic        reset;
    logic        stall_i;
    logic [31:0] instrF;
    logic [31:0] rs1ValE;
    logic [31:0] rs2ValE;
    logic [31:0] pcF_o;
    logic        validE_o;
    logic [31:0] pcE_o;
    logic        mispredictE_o;
    logic [31:0] correctPcE_o;

    // Scenario table
    logic [31:0] rowPc  [NROWS];
    logic        rowJal [NROWS];
    logic [2:0]  rowF3  [NROWS];
    int          rowOff [NROWS];
    int          rowCnt [NROWS];
    logic [31:0] rowRs1 [NROWS][MAXPASS];
    logic [31:0] rowRs2 [NROWS][MAXPASS];

    logic [31:0] imem [16];
    logic [31:0] path [$];
    int          pathIdx;
    int          errors;
    int          seed;
    int          cycleLimit;
    int          resetEdges;
    int          drvPass     [NROWS];
    int          chkPass     [NROWS];
    int          takenPasses [NROWS];

    // Shadow of decode and checker state
    logic        tbValidD;
    logic [31:0] tbPcD;
    logic        prevReset;
    logic        holdCheck;
    logic [31:0] heldPc;
    logic        expectRedirect;
    logic [31:0] redirectPc;

    gshareFrontEnd #(
        .PC_START   (PC_START),
        .BTB_ENTRIES(32),
        .GHR_BITS   (GHR_BITS),
        .PHT_ENTRIES(1024)
    ) u_gshareFrontEnd (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .instrF_i     (instrF),
        .rs1ValE_i    (rs1ValE),
        .rs2ValE_i    (rs2ValE),
        .pcF_o        (pcF_o),
        .validE_o     (validE_o),
        .pcE_o        (pcE_o),
        .mispredictE_o(mispredictE_o),
        .correctPcE_o (correctPcE_o)
    );

    always #4 clk = ~clk;

    // Same-cycle instruction return, NOP outside the program
    assign instrF = (pcF_o < 32'd64) ? imem[pcF_o[5:2]] : NOP;

    function automatic logic [31:0] encodeBranch(input logic [2:0] f3, input int off);
        logic [12:0] imm;
        imm = off[12:0];
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] encodeJal(input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OPCODE_JAL};
    endfunction

    // Architectural outcome of one pass of a row
    function automatic logic condTaken(input int r, input int p);
        logic [31:0] a;
        logic [31:0] b;
        a = rowRs1[r][p];
        b = rowRs2[r][p];
        if (rowJal[r]) begin
            return 1'b1;
        end
        case (rowF3[r])
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int findRow(input logic [31:0] pc);
        for (int i = 0; i < NROWS; i++) begin
            if (rowPc[i] == pc) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic setRow(input int r, input logic [31:0] pc, input logic jal,
                          input logic [2:0] f3, input int off, input int cnt);
        rowPc[r]  = pc;
        rowJal[r] = jal;
        rowF3[r]  = f3;
        rowOff[r] = off;
        rowCnt[r] = cnt;
        for (int p = 0; p < MAXPASS; p++) begin
            rowRs1[r][p] = '0;
            rowRs2[r][p] = '0;
        end
    endtask

    task automatic loadTable();
        // Loop branch BLT, seven taken passes then a not-taken exit
        setRow(0, 32'h0C, 1'b0, 3'b100, -8, 8);
        for (int p = 0; p < 7; p++) begin
            rowRs1[0][p] = 32'hFFFF_FFFF;
            rowRs2[0][p] = 32'd2;
        end
        rowRs1[0][7] = 32'd7;
        rowRs2[0][7] = 32'd2;
        // BEQ not taken on a cold predictor
        setRow(1, 32'h10, 1'b0, 3'b000, 16, 1);
        rowRs1[1][0] = 32'd1;
        rowRs2[1][0] = 32'd2;
        setRow(2, 32'h14, 1'b1, 3'b000, 12, 1);
        // BGEU taken
        setRow(3, 32'h20, 1'b0, 3'b111, 8, 1);
        rowRs1[3][0] = 32'd5;
        rowRs2[3][0] = 32'd3;
    endtask

    task automatic buildProgramAndPath();
        int          r;
        int          left;
        int          passes [NROWS];
        logic [31:0] pc;
        for (int i = 0; i < 16; i++) begin
            imem[i] = NOP;
        end
        left = 0;
        for (int i = 0; i < NROWS; i++) begin
            imem[rowPc[i][5:2]] = rowJal[i] ? encodeJal(rowOff[i])
                                            : encodeBranch(rowF3[i], rowOff[i]);
            passes[i] = 0;
            left += rowCnt[i];
        end
        pc = PC_START;
        while (left > 0 && path.size() < 1000) begin
            path.push_back(pc);
            r = findRow(pc);
            if (r >= 0) begin
                pc = condTaken(r, passes[r]) ? pc + 32'(rowOff[r]) : pc + 32'd4;
                passes[r]++;
                left--;
            end else begin
                pc = pc + 32'd4;
            end
        end
        // A few straight-line instructions after the last branch
        for (int i = 0; i < 3; i++) begin
            path.push_back(pc);
            pc = pc + 32'd4;
        end
    endtask

    task automatic reportError(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        int          r;
        int          p;
        logic        tk;
        logic        nextValidE;
        logic [31:0] nextPcE;
        if ((reset || prevReset) && resetEdges > 0) begin
            if (pcF_o != PC_START || mispredictE_o) begin
                reportError($sformatf("reset state pcF=%h mispredict=%b", pcF_o, mispredictE_o));
            end
        end
        if (reset) begin
            tbValidD       = 1'b0;
            holdCheck      = 1'b0;
            expectRedirect = 1'b0;
            resetEdges++;
            if (resetEdges == 10) begin
                reset <= 1'b0;
            end
            stall_i <= 1'b0;
        end else begin
            if (expectRedirect && pcF_o != redirectPc) begin
                reportError($sformatf("pcF %h after redirect, expected %h", pcF_o, redirectPc));
            end
            if (holdCheck && pcF_o != heldPc) begin
                reportError($sformatf("pcF moved to %h during stall, held %h", pcF_o, heldPc));
            end
            expectRedirect = 1'b0;
            if (validE_o) begin
                if (pathIdx < path.size()) begin
                    if (pcE_o != path[pathIdx]) begin
                        reportError($sformatf("pcE %h, expected %h", pcE_o, path[pathIdx]));
                    end
                    pathIdx++;
                end
                r = findRow(pcE_o);
                if (r >= 0) begin
                    p  = chkPass[r];
                    tk = condTaken(r, p);
                    if (tk) begin
                        takenPasses[r]++;
                        if (takenPasses[r] == 1) begin
                            redirectPc     = rowPc[r] + 32'(rowOff[r]);
                            expectRedirect = 1'b1;
                            if (!mispredictE_o || correctPcE_o != redirectPc) begin
                                reportError($sformatf("first taken at %h: mispredict=%b pc=%h",
                                                      pcE_o, mispredictE_o, correctPcE_o));
                            end
                        end else if (takenPasses[r] > GHR_BITS + 2 && mispredictE_o) begin
                            reportError($sformatf("trained branch %h still mispredicts", pcE_o));
                        end
                    end else begin
                        if (correctPcE_o != rowPc[r] + 32'd4) begin
                            reportError($sformatf("not-taken %h gives %h", pcE_o, correctPcE_o));
                        end
                        if (p == 0 && mispredictE_o) begin
                            reportError($sformatf("cold not-taken %h mispredicts", pcE_o));
                        end
                        if (p > 0 && p == rowCnt[r] - 1 && !mispredictE_o) begin
                            reportError($sformatf("loop exit %h not flagged", pcE_o));
                        end
                    end
                    chkPass[r] = p + 1;
                end else if (mispredictE_o) begin
                    reportError($sformatf("mispredict on non-branch %h", pcE_o));
                end
            end
            holdCheck = stall_i && !mispredictE_o;
            heldPc    = pcF_o;
            // Decode and execute model for operand timing
            nextValidE = tbValidD && !mispredictE_o && !stall_i;
            nextPcE    = tbPcD;
            if (mispredictE_o) begin
                tbValidD = 1'b0;
            end else if (!stall_i) begin
                tbValidD = 1'b1;
                tbPcD    = pcF_o;
            end
            if (nextValidE) begin
                r = findRow(nextPcE);
                if (r >= 0 && drvPass[r] < MAXPASS) begin
                    rs1ValE <= rowRs1[r][drvPass[r]];
                    rs2ValE <= rowRs2[r][drvPass[r]];
                    drvPass[r]++;
                end
            end
            stall_i <= (($random(seed) & 3) == 0);
        end
        prevReset = reset;
    end

    initial begin
        seed           = 97;
        clk            = 1'b0;
        reset          = 1'b1;
        stall_i        = 1'b0;
        rs1ValE        = '0;
        rs2ValE        = '0;
        errors         = 0;
        pathIdx        = 0;
        resetEdges     = 0;
        prevReset      = 1'b0;
        tbValidD       = 1'b0;
        tbPcD          = '0;
        holdCheck      = 1'b0;
        heldPc         = '0;
        expectRedirect = 1'b0;
        redirectPc     = '0;
        cycleLimit     = 200;
        for (int i = 0; i < NROWS; i++) begin
            drvPass[i]     = 0;
            chkPass[i]     = 0;
            takenPasses[i] = 0;
        end
        loadTable();
        buildProgramAndPath();
        for (int i = 0; i < NROWS; i++) begin
            cycleLimit += rowCnt[i] * 8;
        end
        wait (pathIdx == path.size());
        repeat (2) @(posedge clk);
        $display("Summary: %0d errors, %0d of %0d path instructions checked",
                 errors, pathIdx, path.size());
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #1;
        repeat (cycleLimit) @(posedge clk);
        $display("Timeout after %0d cycles, execute stopped at path entry %0d",
                 cycleLimit, pathIdx);
        $display("Test FAILED");
        $finish;
    end

endmodule
